/* src/ks10MemPkg.sv */
/*
 * Shared definitions for the KS10 memory controller.
 * Holds the 36-bit machine word, the decoded bus request and the
 * constants for the device number, the status register address, the
 * flag positions in the bus address word and the RAM geometry.
 * Modules pull these in with a wildcard import in their header.
 */

package ks10MemPkg;

   //////////////////////////////////////////////////
   // Machine word
   //////////////////////////////////////////////////

   // Bit 0 is the most significant bit, as on the KS10
   typedef logic [0:35] ks10Word_t;

   // Decoded form of the bus address word
   typedef struct packed {
      logic        read;
      logic        wrTest;
      logic        write;
      logic        isIo;
      logic [0:3]  dev;
      logic [0:17] addr;
   } memCmd_t;

   //////////////////////////////////////////////////
   // Bus decode constants
   //////////////////////////////////////////////////

   // Memory controller answers as device 0
   localparam logic [0:3] memDev = 4'd0;

   // Memory Status Register IO address
   localparam logic [0:17] addrMsr = 18'o100000;

   // Flag bits in the upper part of the address word
   localparam int busFlagRead   = 3;
   localparam int busFlagWrTest = 4;
   localparam int busFlagWrite  = 5;
   localparam int busFlagIo     = 10;

   //////////////////////////////////////////////////
   // Memory geometry and status register layout
   //////////////////////////////////////////////////

   // 32K words populated on chip
   localparam int memAddrBits  = 15;
   localparam int memAddrWords = 1 << memAddrBits;

   // Status register bits, read and write views
   localparam int msrBitPe = 3;
   localparam int msrBitEe = 4;
   localparam int msrBitPf = 12;
   // Write only, ECC disable
   localparam int msrBitEd = 35;

endpackage

/* src/memBusDecode.sv */
/*
 * Backplane bus front end of the memory controller.
 * Splits the bus address word into flags, device and address, decides
 * whether the controller owns the request and steers writes to the RAM
 * or the status register. The acknowledge and the read data source are
 * registered, so busAck and busDataOut appear one enabled cycle later.
 */

`timescale 1ns/1ps

module memBusDecode
   import ks10MemPkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   clken,
   input  logic                   busReq,
   input  ks10Word_t              busAddr,
   input  ks10Word_t              busDataIn,
   output logic                   busAck,
   output ks10Word_t              busDataOut,
   output logic [memAddrBits-1:0] ramAddr,
   output logic                   ramWrite,
   output ks10Word_t              ramWriteData,
   input  ks10Word_t              ramReadData,
   output logic                   msrWrite,
   output ks10Word_t              msrWriteData,
   input  ks10Word_t              msrWord
);

   memCmd_t cmd;
   logic    inRange;
   logic    msrSel;
   logic    memSel;
   logic    owned;
   logic    ackQ;
   logic    selMsrQ;
   logic    zeroQ;

   //////////////////////////////////////////////////
   // Request unpack
   //////////////////////////////////////////////////

   // Flags sit in bits 0..13, device and address below them
   assign cmd.read   = busAddr[busFlagRead];
   assign cmd.wrTest = busAddr[busFlagWrTest];
   assign cmd.write  = busAddr[busFlagWrite];
   assign cmd.isIo   = busAddr[busFlagIo];
   assign cmd.dev    = busAddr[14:17];
   assign cmd.addr   = busAddr[18:35];

   // Only the low 32K words exist
   assign inRange = cmd.addr < 18'(memAddrWords);

   //////////////////////////////////////////////////
   // Ownership
   //////////////////////////////////////////////////

   // Status register takes IO reads and writes at its one address
   assign msrSel = cmd.isIo & (cmd.dev == memDev) & (cmd.addr == addrMsr) &
                   (cmd.read | cmd.write);

   // Reads need a populated word; writes and write-tests always answer
   assign memSel = ~cmd.isIo & ((cmd.read & inRange) | cmd.write | cmd.wrTest);

   assign owned = busReq & (msrSel | memSel);

   // Write strobes; the enable is applied at the targets
   assign ramWrite = busReq & ~cmd.isIo & cmd.write & inRange;
   assign msrWrite = busReq & msrSel & cmd.write;

   assign ramAddr      = cmd.addr[18 - memAddrBits +: memAddrBits];
   assign ramWriteData = busDataIn;
   assign msrWriteData = busDataIn;

   //////////////////////////////////////////////////
   // Acknowledge stage
   //////////////////////////////////////////////////

   // Holds through disabled cycles
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ackQ    <= 1'b0;
         selMsrQ <= 1'b0;
         zeroQ   <= 1'b0;
      end
      else if (clken)
      begin
         ackQ    <= owned;
         selMsrQ <= msrSel;
         // Out of range write-test reads back as zero
         zeroQ   <= memSel & ~inRange;
      end
   end

   assign busAck = ackQ;

   // Return data lines up with the registered RAM read
   always_comb
   begin
      if (selMsrQ)
         busDataOut = msrWord;
      else if (zeroQ)
         busDataOut = '0;
      else
         busDataOut = ramReadData;
   end

endmodule

/* src/memStatusReg.sv */
/*
 * Memory Status Register at IO address 100000 octal.
 * Keeps the parity error, ECC enable and power fail bits. A write
 * lands on the enabled edge of its request; msrWord always shows the
 * current read-back layout, so the next request sees the new value.
 */

`timescale 1ns/1ps

module memStatusReg
   import ks10MemPkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      clken,
   input  logic      msrWrite,
   input  ks10Word_t msrWriteData,
   output ks10Word_t msrWord
);

   // Parity error
   logic statPe;
   // ECC enabled
   logic statEe;
   // Power failure, set at power-up
   logic statPf;

   //////////////////////////////////////////////////
   // Register state
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         statPe <= 1'b0;
         statEe <= 1'b1;
         statPf <= 1'b1;
      end
      else if (clken && msrWrite)
      begin
         statPe <= msrWriteData[msrBitPe];
         // Writing zero clears PF, a one never sets it again
         statPf <= msrWriteData[msrBitPf] & statPf;
         // ED written as one turns ECC off
         statEe <= ~msrWriteData[msrBitEd];
      end
   end

   // Read-back word
   // Error hold, ECC fields and error address all read as zero
   always_comb
   begin
      msrWord           = '0;
      msrWord[msrBitPe] = statPe;
      msrWord[msrBitEe] = statEe;
      msrWord[msrBitPf] = statPf;
   end

endmodule

/* src/memArray.sv */
/*
 * On-chip main memory standing in for the external SSRAM.
 * Single port, one 36-bit word per address. Writes happen on enabled
 * edges; the addressed word is read every enabled edge and appears on
 * ramReadData one enabled cycle after the address.
 */

`timescale 1ns/1ps

module memArray
   import ks10MemPkg::*;
(
   input  logic                   clk,
   input  logic                   clken,
   input  logic [memAddrBits-1:0] ramAddr,
   input  logic                   ramWrite,
   input  ks10Word_t              ramWriteData,
   output ks10Word_t              ramReadData
);

   //////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////

   // Contents undefined until written
   ks10Word_t mem [memAddrWords];

   //////////////////////////////////////////////////
   // Write and registered read
   //////////////////////////////////////////////////

   // Write port
   always_ff @(posedge clk)
   begin
      if (clken && ramWrite)
      begin
         mem[ramAddr] <= ramWriteData;
      end
   end

   // Read port
   // Old data comes back when the same address is written
   always_ff @(posedge clk)
   begin
      if (clken)
      begin
         ramReadData <= mem[ramAddr];
      end
   end

endmodule

/* src/memTop.sv */
/*
 * Memory controller top level as seen from the backplane bus.
 * Ties the bus decode stage to the status register and the word RAM.
 * Owned requests are acknowledged one enabled cycle after the request.
 */

`timescale 1ns/1ps

module memTop
   import ks10MemPkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      clken,
   input  logic      busReq,
   input  ks10Word_t busAddr,
   input  ks10Word_t busDataIn,
   output logic      busAck,
   output ks10Word_t busDataOut
);

   // RAM side
   logic [memAddrBits-1:0] ramAddr;
   logic                   ramWrite;
   ks10Word_t              ramWriteData;
   ks10Word_t              ramReadData;

   // Status register side
   logic      msrWrite;
   ks10Word_t msrWriteData;
   ks10Word_t msrWord;

   // Bus front end
   memBusDecode uDecode (
      .clk          (clk),
      .rst          (rst),
      .clken        (clken),
      .busReq       (busReq),
      .busAddr      (busAddr),
      .busDataIn    (busDataIn),
      .busAck       (busAck),
      .busDataOut   (busDataOut),
      .ramAddr      (ramAddr),
      .ramWrite     (ramWrite),
      .ramWriteData (ramWriteData),
      .ramReadData  (ramReadData),
      .msrWrite     (msrWrite),
      .msrWriteData (msrWriteData),
      .msrWord      (msrWord)
   );

   // Status register at IO 100000
   memStatusReg uStatus (
      .clk          (clk),
      .rst          (rst),
      .clken        (clken),
      .msrWrite     (msrWrite),
      .msrWriteData (msrWriteData),
      .msrWord      (msrWord)
   );

   // Main memory
   memArray uArray (
      .clk          (clk),
      .clken        (clken),
      .ramAddr      (ramAddr),
      .ramWrite     (ramWrite),
      .ramWriteData (ramWriteData),
      .ramReadData  (ramReadData)
   );

endmodule

/* tests/memTop_props.sv */
/*
 * Concurrent checks on the memory controller acknowledge.
 * Bound to memTop from the testbench top; reports only through
 * failing assertions.
 */

`timescale 1ns/1ps

module memTop_props (
   input logic clk,
   input logic rst,
   input logic clken,
   input logic busReq,
   input logic busAck
);

   // Request seen at the last enabled edge
   logic reqSeen;

   always_ff @(posedge clk)
   begin
      if (rst)
         reqSeen <= 1'b0;
      else if (clken)
         reqSeen <= busReq;
   end

   // Reset clears the acknowledge
   ackLowAfterReset: assert property (@(posedge clk) rst |=> !busAck)
      else $error("busAck high in the cycle after reset");

   // Ack only answers a request from the previous enabled edge
   ackNeedsRequest: assert property (@(posedge clk) disable iff (rst) busAck |-> reqSeen)
      else $error("busAck high without a request at the previous enabled edge");

   // Gated edges leave busAck alone
   ackHoldsWhenGated: assert property (@(posedge clk) disable iff (rst)
      !clken |=> $stable(busAck))
      else $error("busAck changed on an edge with clken low");

endmodule

/* tests/memChecker.sv */
/*
 * Response checker for the memory controller testbench.
 * Samples the bus ports on every clock edge, keeps a memory and status
 * register model built from the bus rules, and compares busAck and
 * busDataOut one enabled cycle after each request. Prints a line per
 * finished test and exposes the counts to the testbench top.
 */

`timescale 1ns/1ps

module memChecker
   import ks10MemPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        clken,
   input  logic        busReq,
   input  ks10Word_t   busAddr,
   input  ks10Word_t   busDataIn,
   input  logic        busAck,
   input  ks10Word_t   busDataOut,
   input  logic [63:0] testName,
   input  logic        testEnd,
   output logic        busy,
   output int          testCount,
   output int          failCount,
   output int          errorCount
);

   // Reference memory, sparse
   ks10Word_t   memModel [int];
   // Status register model
   logic        pe;
   logic        ee;
   logic        pf;
   // What the last enabled edge should produce
   logic        expAck;
   logic        expHasData;
   ks10Word_t   expData;
   logic [63:0] expName;
   int          testErrors;

   always @(posedge clk)
   begin
      logic        rd;
      logic        wt;
      logic        wr;
      logic        io;
      logic        inRange;
      logic [0:3]  dev;
      logic [0:17] addr;
      if (rst)
      begin
         pe         = 1'b0;
         ee         = 1'b1;
         pf         = 1'b1;
         expAck     = 1'b0;
         expHasData = 1'b0;
         expData    = '0;
         expName    = '0;
         busy       = 1'b0;
         testErrors = 0;
         testCount  = 0;
         failCount  = 0;
         errorCount = 0;
      end
      else
      begin
         //////////////////////////////////////////////////
         // Response to the previous enabled request
         //////////////////////////////////////////////////
         if (busAck !== expAck)
         begin
            errorCount++;
            testErrors++;
            if (expAck)
               $display("%0s: acknowledge missing", expName);
            else
               $display("%0s: acknowledge without an owned request", expName);
         end
         else if (clken && expHasData && busDataOut !== expData)
         begin
            errorCount++;
            testErrors++;
            $display("Mismatch %0s: expected %012o, actual %012o",
                     expName, expData, busDataOut);
         end

         //////////////////////////////////////////////////
         // New request, sampled on enabled edges only
         //////////////////////////////////////////////////
         if (clken)
         begin
            rd         = busAddr[busFlagRead];
            wt         = busAddr[busFlagWrTest];
            wr         = busAddr[busFlagWrite];
            io         = busAddr[busFlagIo];
            dev        = busAddr[14:17];
            addr       = busAddr[18:35];
            inRange    = int'(addr) < memAddrWords;
            expName    = testName;
            expAck     = 1'b0;
            expHasData = 1'b0;
            expData    = '0;
            busy       = busReq;
            if (busReq && io && dev == memDev && addr == addrMsr && (rd || wr))
            begin
               expAck     = 1'b1;
               expHasData = rd;
               if (wr)
               begin
                  pe = busDataIn[msrBitPe];
                  ee = ~busDataIn[msrBitEd];
                  // PF only ever clears
                  pf = pf & busDataIn[msrBitPf];
               end
               expData[msrBitPe] = pe;
               expData[msrBitEe] = ee;
               expData[msrBitPf] = pf;
            end
            else if (busReq && !io && (wr || wt || (rd && inRange)))
            begin
               expAck     = 1'b1;
               expHasData = rd || wt;
               if (inRange && memModel.exists(int'(addr)))
                  expData = memModel[int'(addr)];
               if (wr && inRange)
                  memModel[int'(addr)] = busDataIn;
            end
         end

         // Summary line per test
         if (testEnd)
         begin
            testCount++;
            if (testErrors == 0)
               $display("Test %0s: ok", testName);
            else
            begin
               failCount++;
               $display("Test %0s: %0d errors", testName, testErrors);
            end
            testErrors = 0;
         end
      end
   end

endmodule

/* tests/memTb.sv */
/*
 * Testbench top for the KS10 memory controller.
 * Walks a table of bus requests, back to back within a test, with a
 * clken pattern per request. After each test the bus goes idle and the
 * checker prints the test's line. Run it through the Makefile.
 */

`timescale 1ns/1ps

module memTb
   import ks10MemPkg::*;
();

   localparam int numSteps   = 23;
   localparam int drainLimit = 20;

   // Request kind bits for read, write-test, write and IO
   localparam logic [3:0] opRd = 4'b1000;
   localparam logic [3:0] opWt = 4'b0100;
   localparam logic [3:0] opWr = 4'b0010;
   localparam logic [3:0] opIo = 4'b0001;

   // One table entry
   typedef struct packed {
      logic [63:0] name;
      logic [3:0]  op;
      logic [0:3]  dev;
      logic [0:17] addr;
      ks10Word_t   data;
      logic        randData;
      // Zero selects the fixed address and 1 to 3 a random slot
      logic [1:0]  slot;
      // clken per cycle from the LSB up to the first one
      logic [3:0]  pat;
   } step_t;

   logic        clk;
   logic        rst;
   logic        clken;
   logic        busReq;
   ks10Word_t   busAddr;
   ks10Word_t   busDataIn;
   logic        busAck;
   ks10Word_t   busDataOut;
   logic [63:0] testName;
   logic        testEnd;
   logic        busy;
   int          testCount;
   int          failCount;
   int          errorCount;
   step_t       steps [numSteps];
   logic [0:17] slotAddr [1:3];

   memTop u_memTop (
      .clk        (clk),
      .rst        (rst),
      .clken      (clken),
      .busReq     (busReq),
      .busAddr    (busAddr),
      .busDataIn  (busDataIn),
      .busAck     (busAck),
      .busDataOut (busDataOut)
   );

   memChecker uChecker (
      .clk        (clk),
      .rst        (rst),
      .clken      (clken),
      .busReq     (busReq),
      .busAddr    (busAddr),
      .busDataIn  (busDataIn),
      .busAck     (busAck),
      .busDataOut (busDataOut),
      .testName   (testName),
      .testEnd    (testEnd),
      .busy       (busy),
      .testCount  (testCount),
      .failCount  (failCount),
      .errorCount (errorCount)
   );

   bind memTop memTop_props uProps (
      .clk    (clk),
      .rst    (rst),
      .clken  (clken),
      .busReq (busReq),
      .busAck (busAck)
   );

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   function automatic step_t makeStep(input logic [63:0] name, input logic [3:0] op,
                                      input logic [0:3] dev, input logic [0:17] addr,
                                      input ks10Word_t data, input logic randData,
                                      input logic [1:0] slot, input logic [3:0] pat);
      return '{name, op, dev, addr, data, randData, slot, pat};
   endfunction

   // Bus address word from flags, device and address
   function automatic ks10Word_t buildAddr(input logic [3:0] op, input logic [0:3] dev,
                                           input logic [0:17] addr);
      ks10Word_t w;
      w                = '0;
      w[busFlagRead]   = op[3];
      w[busFlagWrTest] = op[2];
      w[busFlagWrite]  = op[1];
      w[busFlagIo]     = op[0];
      w[14:17]         = dev;
      w[18:35]         = addr;
      return w;
   endfunction

   function automatic ks10Word_t randWord();
      logic [63:0] r;
      r = {$urandom(), $urandom()};
      return r[35:0];
   endfunction

   // Idle the bus, wait for the acknowledge to clear and close the test
   task automatic finishTest(output logic drained);
      int waitCount;
      @(posedge clk);
      busReq    <= 1'b0;
      clken     <= 1'b1;
      waitCount = 0;
      do
      begin
         @(negedge clk);
         waitCount++;
      end while ((busy || busAck) && waitCount < drainLimit);
      drained = !(busy || busAck);
      if (!drained)
      begin
         $display("Timeout: test %0s did not drain", testName);
      end
      else
      begin
         @(posedge clk);
         testEnd <= 1'b1;
         @(posedge clk);
         testEnd <= 1'b0;
      end
   endtask

   //////////////////////////////////////////////////
   // Clock and stimulus
   //////////////////////////////////////////////////

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial
   begin
      int          i;
      int          k;
      logic [0:17] addr;
      ks10Word_t   data;
      logic        drained;
      void'($urandom(32'h6adf));
      rst       = 1'b1;
      clken     = 1'b1;
      busReq    = 1'b0;
      busAddr   = '0;
      busDataIn = '0;
      testName  = '0;
      testEnd   = 1'b0;
      drained   = 1'b1;

      // One random address per 8K quarter keeps the slots distinct
      for (k = 1; k <= 3; k++)
         slotAddr[k] = 18'(($urandom() % 8192) + k * 8192);

      steps[0]  = makeStep("msrReset", opRd | opIo, 4'd0, addrMsr, '0, 1'b0, 2'd0, 4'b0001);
      // PE set, ECC off, PF cleared
      steps[1]  = makeStep("msrWrite", opWr | opIo, 4'd0, addrMsr, 36'h100000001, 1'b0, 2'd0,
                           4'b0001);
      steps[2]  = makeStep("msrWrite", opRd | opIo, 4'd0, addrMsr, '0, 1'b0, 2'd0, 4'b0001);
      // Bit 12 set but PF must stay clear
      steps[3]  = makeStep("msrWrite", opWr | opIo, 4'd0, addrMsr, 36'h000800000, 1'b0, 2'd0,
                           4'b0001);
      steps[4]  = makeStep("msrWrite", opRd | opIo, 4'd0, addrMsr, '0, 1'b0, 2'd0, 4'b0001);
      steps[5]  = makeStep("memWrRd ", opWr, 4'd0, 18'o0, '0, 1'b1, 2'd1, 4'b0001);
      steps[6]  = makeStep("memWrRd ", opWr, 4'd0, 18'o0, '0, 1'b1, 2'd2, 4'b0001);
      steps[7]  = makeStep("memWrRd ", opWr, 4'd0, 18'o0, '0, 1'b1, 2'd3, 4'b0001);
      steps[8]  = makeStep("memWrRd ", opRd, 4'd0, 18'o0, '0, 1'b0, 2'd1, 4'b0001);
      steps[9]  = makeStep("memWrRd ", opRd, 4'd0, 18'o0, '0, 1'b0, 2'd2, 4'b0001);
      steps[10] = makeStep("memWrRd ", opRd, 4'd0, 18'o0, '0, 1'b0, 2'd3, 4'b0001);
      steps[11] = makeStep("wrTest  ", opWt, 4'd0, 18'o0, '0, 1'b1, 2'd1, 4'b0001);
      steps[12] = makeStep("wrTest  ", opRd, 4'd0, 18'o0, '0, 1'b0, 2'd1, 4'b0001);
      steps[13] = makeStep("wrTest  ", opWt, 4'd0, 18'o700000, '0, 1'b0, 2'd0, 4'b0001);
      steps[14] = makeStep("unowned ", opWr, 4'd0, 18'o0, 36'o123456701234, 1'b0, 2'd0, 4'b0001);
      steps[15] = makeStep("unowned ", opRd, 4'd0, 18'o100000, '0, 1'b0, 2'd0, 4'b0001);
      steps[16] = makeStep("unowned ", opRd | opIo, 4'd3, addrMsr, '0, 1'b0, 2'd0, 4'b0001);
      steps[17] = makeStep("unowned ", opRd | opIo, 4'd0, 18'o100001, '0, 1'b0, 2'd0, 4'b0001);
      // Would alias onto word 0 if not blocked
      steps[18] = makeStep("unowned ", opWr, 4'd0, 18'o100000, '0, 1'b1, 2'd0, 4'b0001);
      steps[19] = makeStep("unowned ", opRd, 4'd0, 18'o0, '0, 1'b0, 2'd0, 4'b0001);
      steps[20] = makeStep("clkenGap", opWr, 4'd0, 18'o0, '0, 1'b1, 2'd2, 4'b1010);
      steps[21] = makeStep("clkenGap", opRd, 4'd0, 18'o0, '0, 1'b0, 2'd2, 4'b1000);
      steps[22] = makeStep("clkenGap", opRd | opIo, 4'd0, addrMsr, '0, 1'b0, 2'd0, 4'b0100);

      repeat (2) @(posedge clk);
      rst <= 1'b0;

      for (i = 0; i < numSteps; i++)
      begin
         addr = (steps[i].slot == 2'd0) ? steps[i].addr : slotAddr[steps[i].slot];
         data = steps[i].randData ? randWord() : steps[i].data;
         // Hold the request until an enabled edge takes it
         for (k = 0; k < 4; k++)
         begin
            @(posedge clk);
            busReq    <= 1'b1;
            busAddr   <= buildAddr(steps[i].op, steps[i].dev, addr);
            busDataIn <= data;
            testName  <= steps[i].name;
            clken     <= steps[i].pat[k];
            if (steps[i].pat[k])
               break;
         end
         if (i == numSteps - 1 || steps[i + 1].name != steps[i].name)
         begin
            finishTest(drained);
            if (!drained)
               break;
         end
      end

      @(negedge clk);
      $display("Tests: %0d, failed: %0d, errors: %0d", testCount, failCount, errorCount);
      if (errorCount == 0 && drained)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

/* project.f */
src/ks10MemPkg.sv
src/memBusDecode.sv
src/memStatusReg.sv
src/memArray.sv
src/memTop.sv
tests/memTop_props.sv
tests/memChecker.sv
tests/memTb.sv

/* Makefile */
# Verilator build and run of the KS10 memory controller testbench
# The binary is rebuilt only when the file list or a source changes

obj_dir/VmemTb: project.f $(wildcard src/*.sv tests/*.sv)
	verilator --binary --timing --assert --top-module memTb -f project.f

run: obj_dir/VmemTb
	obj_dir/VmemTb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Done: errors found" sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
